// ==== mips_id_pkg.sv ====
`default_nettype none

package mips_id_pkg;

    // instruction word layout
    localparam int OP_MSB     = 31;
    localparam int OP_W       = 6;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SA_LSB     = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;
    localparam int SA_W       = 5;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // SPECIAL function field, kept ops only
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000, F_SRL  = 6'b000010, F_SRA  = 6'b000011,
        F_SLLV = 6'b000100, F_SRLV = 6'b000110, F_SRAV = 6'b000111,
        F_MOVZ = 6'b001010, F_MOVN = 6'b001011,
        F_ADD  = 6'b100000, F_ADDU = 6'b100001,
        F_SUB  = 6'b100010, F_SUBU = 6'b100011,
        F_AND  = 6'b100100, F_OR   = 6'b100101,
        F_XOR  = 6'b100110, F_NOR  = 6'b100111,
        F_SLT  = 6'b101010, F_SLTU = 6'b101011
    } funct_e;

    // immediate forms reuse these
    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_AND  = 8'h24, ALU_OR   = 8'h25, ALU_XOR  = 8'h26, ALU_NOR  = 8'h27,
        ALU_LUI  = 8'h5c,
        ALU_SLL  = 8'h7c, ALU_SRL  = 8'h02, ALU_SRA  = 8'h03,
        ALU_ADD  = 8'h20, ALU_ADDU = 8'h21, ALU_SUB  = 8'h22, ALU_SUBU = 8'h23,
        ALU_SLT  = 8'h2a, ALU_SLTU = 8'h2b,
        ALU_MOVZ = 8'h0a, ALU_MOVN = 8'h0b
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

endpackage

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import mips_id_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  we_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    input  wire logic [DATA_W-1:0]     wdata_i,
    input  wire logic [REG_ADDR_W-1:0] raddr1_i,
    input  wire logic [REG_ADDR_W-1:0] raddr2_i,
    output logic      [DATA_W-1:0]     rdata1_o,
    output logic      [DATA_W-1:0]     rdata2_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_live;

    assign wr_live = we_i && (waddr_i != '0);  // $zero is never written

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so the reader sees a write-back landing this edge
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] raddr);
        if (raddr == '0) begin
            return '0;
        end else if (wr_live && (raddr == waddr_i)) begin
            return wdata_i;
        end
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import mips_id_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wire logic [31:0]           inst_i,
    output logic                       rd1_en_o,
    output logic                       rd2_en_o,
    output aluop_e                     aluop_o,
    output alusel_e                    alusel_o,
    output logic      [DATA_W-1:0]     imm_o,
    output logic      [REG_ADDR_W-1:0] wd_o,
    output logic                       wreg_o,
    output logic                       cond_move_o,
    output logic                       invalid_o
);

    // operand and destination layout of a decoded word
    typedef enum logic [2:0] {
        FORM_NONE,
        FORM_RR,
        FORM_MOVE,
        FORM_SHIFT_SA,
        FORM_IMM_ZX,
        FORM_IMM_SX,
        FORM_IMM_HI
    } form_e;

    opcode_e               opcode;
    funct_e                funct;
    form_e                 form;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SA_W-1:0]       sa;
    logic [IMM_W-1:0]      imm16;
    logic                  sa_shift;

    assign opcode = opcode_e'(inst_i[OP_MSB -: OP_W]);
    assign funct  = funct_e'(inst_i[FUNCT_W-1:0]);
    assign rs     = inst_i[RS_LSB +: REG_ADDR_W];
    assign rt     = inst_i[RT_LSB +: REG_ADDR_W];
    assign rd     = inst_i[RD_LSB +: REG_ADDR_W];
    assign sa     = inst_i[SA_LSB +: SA_W];
    assign imm16  = inst_i[IMM_W-1:0];

    // sll/srl/sra need the top eleven bits clear
    assign sa_shift = (opcode == OP_SPECIAL) && (rs == '0) &&
                      (funct inside {F_SLL, F_SRL, F_SRA});

    always_comb begin
        aluop_o = ALU_NOP;
        case (opcode)
            OP_ORI:   aluop_o = ALU_OR;
            OP_ANDI:  aluop_o = ALU_AND;
            OP_XORI:  aluop_o = ALU_XOR;
            OP_LUI:   aluop_o = ALU_LUI;
            OP_SLTI:  aluop_o = ALU_SLT;
            OP_SLTIU: aluop_o = ALU_SLTU;
            OP_ADDI:  aluop_o = ALU_ADD;
            OP_ADDIU: aluop_o = ALU_ADDU;
            OP_SPECIAL: begin
                if (sa_shift) begin
                    case (funct)
                        F_SRL:   aluop_o = ALU_SRL;
                        F_SRA:   aluop_o = ALU_SRA;
                        default: aluop_o = ALU_SLL;
                    endcase
                end else if (sa == '0) begin  // register-register forms
                    case (funct)
                        F_AND:   aluop_o = ALU_AND;
                        F_OR:    aluop_o = ALU_OR;
                        F_XOR:   aluop_o = ALU_XOR;
                        F_NOR:   aluop_o = ALU_NOR;
                        F_SLLV:  aluop_o = ALU_SLL;
                        F_SRLV:  aluop_o = ALU_SRL;
                        F_SRAV:  aluop_o = ALU_SRA;
                        F_ADD:   aluop_o = ALU_ADD;
                        F_ADDU:  aluop_o = ALU_ADDU;
                        F_SUB:   aluop_o = ALU_SUB;
                        F_SUBU:  aluop_o = ALU_SUBU;
                        F_SLT:   aluop_o = ALU_SLT;
                        F_SLTU:  aluop_o = ALU_SLTU;
                        F_MOVN:  aluop_o = ALU_MOVN;
                        F_MOVZ:  aluop_o = ALU_MOVZ;
                        default: aluop_o = ALU_NOP;
                    endcase
                end
            end
            default:  aluop_o = ALU_NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ORI, OP_ANDI, OP_XORI:             form = FORM_IMM_ZX;
            OP_LUI:                               form = FORM_IMM_HI;
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: form = FORM_IMM_SX;
            OP_SPECIAL: begin
                if (sa_shift) begin
                    form = FORM_SHIFT_SA;
                end else if (aluop_o inside {ALU_MOVN, ALU_MOVZ}) begin
                    form = FORM_MOVE;
                end else begin
                    form = (aluop_o == ALU_NOP) ? FORM_NONE : FORM_RR;
                end
            end
            default:                              form = FORM_NONE;
        endcase
    end

    always_comb begin
        case (aluop_o)
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI:   alusel_o = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:                    alusel_o = SEL_SHIFT;
            ALU_MOVN, ALU_MOVZ:                           alusel_o = SEL_MOVE;
            ALU_NOP:                                      alusel_o = SEL_NOP;
            default:                                      alusel_o = SEL_ARITH;
        endcase
    end

    always_comb begin
        rd1_en_o = 1'b0;
        rd2_en_o = 1'b0;
        wd_o     = '0;
        imm_o    = '0;
        case (form)
            FORM_RR, FORM_MOVE: begin
                rd1_en_o = 1'b1;
                rd2_en_o = 1'b1;
                wd_o     = rd;
            end
            FORM_SHIFT_SA: begin
                rd2_en_o = 1'b1;
                wd_o     = rd;
                imm_o    = DATA_W'(sa);
            end
            FORM_IMM_ZX, FORM_IMM_SX, FORM_IMM_HI: begin
                rd1_en_o = 1'b1;
                wd_o     = rt;
                if (form == FORM_IMM_SX) begin
                    imm_o = DATA_W'($signed(imm16));
                end else if (form == FORM_IMM_HI) begin
                    imm_o = DATA_W'(imm16) << (DATA_W - IMM_W);
                end else begin
                    imm_o = DATA_W'(imm16);
                end
            end
            default: ;
        endcase
        wreg_o      = (form != FORM_NONE) && (form != FORM_MOVE);
        cond_move_o = (form == FORM_MOVE);  // selector decides wreg
        invalid_o   = (form == FORM_NONE);
    end

endmodule

`default_nettype wire

// ==== operand_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_select import mips_id_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [REG_ADDR_W-1:0] rs_i,
    input  wire logic [REG_ADDR_W-1:0] rt_i,
    input  wire logic                  rd1_en_i,
    input  wire logic                  rd2_en_i,
    input  wire aluop_e                aluop_i,
    input  wire alusel_e               alusel_i,
    input  wire logic [DATA_W-1:0]     imm_i,
    input  wire logic [REG_ADDR_W-1:0] wd_i,
    input  wire logic                  wreg_i,
    input  wire logic                  cond_move_i,
    input  wire logic                  invalid_i,
    input  wire logic [DATA_W-1:0]     rdata1_i,
    input  wire logic [DATA_W-1:0]     rdata2_i,
    input  wire logic                  ex_wreg_i,
    input  wire logic [REG_ADDR_W-1:0] ex_wd_i,
    input  wire logic [DATA_W-1:0]     ex_wdata_i,
    input  wire logic                  mem_wreg_i,
    input  wire logic [REG_ADDR_W-1:0] mem_wd_i,
    input  wire logic [DATA_W-1:0]     mem_wdata_i,
    output aluop_e                     aluop_o,
    output alusel_e                    alusel_o,
    output logic      [DATA_W-1:0]     reg1_o,
    output logic      [DATA_W-1:0]     reg2_o,
    output logic      [REG_ADDR_W-1:0] wd_o,
    output logic                       wreg_o,
    output logic                       inst_invalid_o
);

    logic [DATA_W-1:0] op1;
    logic [DATA_W-1:0] op2;
    logic              wreg_final;

    // EX data is newest, then MEM, then the register file
    function automatic logic [DATA_W-1:0] pick(
        input logic                  en,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [DATA_W-1:0]     rf_data
    );
        if (!en) begin
            return imm_i;
        end else if (ex_wreg_i && (ex_wd_i == addr)) begin
            return ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == addr)) begin
            return mem_wdata_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        op1        = pick(rd1_en_i, rs_i, rdata1_i);
        op2        = pick(rd2_en_i, rt_i, rdata2_i);
        wreg_final = wreg_i;
        if (cond_move_i) begin  // movn on nonzero, movz on zero
            wreg_final = (aluop_i == ALU_MOVN) ? (op2 != '0) : (op2 == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            aluop_o        <= ALU_NOP;
            alusel_o       <= SEL_NOP;
            reg1_o         <= '0;
            reg2_o         <= '0;
            wd_o           <= '0;
            wreg_o         <= 1'b0;
            inst_invalid_o <= 1'b0;
        end else begin
            aluop_o        <= aluop_i;
            alusel_o       <= alusel_i;
            reg1_o         <= op1;
            reg2_o         <= op2;
            wd_o           <= wd_i;
            wreg_o         <= wreg_final;
            inst_invalid_o <= invalid_i;
        end
    end

    // decoder and move resolution must never write for a bad word
    assert property (@(posedge clk) disable iff (reset_i) wreg_o |-> !inst_invalid_o)
        else $error("operand_select: write enabled on an invalid instruction");

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_stage import mips_id_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [31:0]           inst_i,
    input  wire logic                  wb_we_i,
    input  wire logic [REG_ADDR_W-1:0] wb_addr_i,
    input  wire logic [DATA_W-1:0]     wb_data_i,
    input  wire logic                  ex_wreg_i,
    input  wire logic [REG_ADDR_W-1:0] ex_wd_i,
    input  wire logic [DATA_W-1:0]     ex_wdata_i,
    input  wire logic                  mem_wreg_i,
    input  wire logic [REG_ADDR_W-1:0] mem_wd_i,
    input  wire logic [DATA_W-1:0]     mem_wdata_i,
    output aluop_e                     aluop_o,
    output alusel_e                    alusel_o,
    output logic      [DATA_W-1:0]     reg1_o,
    output logic      [DATA_W-1:0]     reg2_o,
    output logic      [REG_ADDR_W-1:0] wd_o,
    output logic                       wreg_o,
    output logic                       inst_invalid_o
);

    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [DATA_W-1:0]     rd1_data;
    logic [DATA_W-1:0]     rd2_data;
    logic                  rd1_en;
    logic                  rd2_en;
    aluop_e                aluop;
    alusel_e               alusel;
    logic [DATA_W-1:0]     imm;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic                  cond_move;
    logic                  invalid;

    // read addresses go out before decode settles
    assign rs = inst_i[RS_LSB +: REG_ADDR_W];
    assign rt = inst_i[RT_LSB +: REG_ADDR_W];

    reg_file #(.DATA_W(DATA_W)) u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .rdata1_o (rd1_data),
        .rdata2_o (rd2_data)
    );

    inst_decoder #(.DATA_W(DATA_W)) u_inst_decoder (
        .inst_i      (inst_i),
        .rd1_en_o    (rd1_en),
        .rd2_en_o    (rd2_en),
        .aluop_o     (aluop),
        .alusel_o    (alusel),
        .imm_o       (imm),
        .wd_o        (wd),
        .wreg_o      (wreg),
        .cond_move_o (cond_move),
        .invalid_o   (invalid)
    );

    operand_select #(.DATA_W(DATA_W)) u_operand_select (
        .clk            (clk),
        .reset_i        (reset_i),
        .rs_i           (rs),
        .rt_i           (rt),
        .rd1_en_i       (rd1_en),
        .rd2_en_i       (rd2_en),
        .aluop_i        (aluop),
        .alusel_i       (alusel),
        .imm_i          (imm),
        .wd_i           (wd),
        .wreg_i         (wreg),
        .cond_move_i    (cond_move),
        .invalid_i      (invalid),
        .rdata1_i       (rd1_data),
        .rdata2_i       (rd2_data),
        .ex_wreg_i      (ex_wreg_i),
        .ex_wd_i        (ex_wd_i),
        .ex_wdata_i     (ex_wdata_i),
        .mem_wreg_i     (mem_wreg_i),
        .mem_wd_i       (mem_wd_i),
        .mem_wdata_i    (mem_wdata_i),
        .aluop_o        (aluop_o),
        .alusel_o       (alusel_o),
        .reg1_o         (reg1_o),
        .reg2_o         (reg2_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .inst_invalid_o (inst_invalid_o)
    );

endmodule

`default_nettype wire

// ==== tb_id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage import mips_id_pkg::*; ();

    localparam int DATA_W     = 32;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYC  = 4;
    localparam int NUM_COLS   = 17;  // 10 stimulus + 7 expected
    localparam int MAX_VECS   = 256;

    logic                  clk;
    logic                  reset_i;
    logic [31:0]           inst;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic                  ex_wreg;
    logic [REG_ADDR_W-1:0] ex_wd;
    logic [DATA_W-1:0]     ex_wdata;
    logic                  mem_wreg;
    logic [REG_ADDR_W-1:0] mem_wd;
    logic [DATA_W-1:0]     mem_wdata;
    aluop_e                aluop;
    alusel_e               alusel;
    logic [DATA_W-1:0]     reg1;
    logic [DATA_W-1:0]     reg2;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic                  inst_invalid;

    logic [31:0] vec_tab [MAX_VECS][NUM_COLS];
    int          num_vecs;
    logic        stim_loaded;

    id_stage #(.DATA_W(DATA_W)) dut_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_i         (inst),
        .wb_we_i        (wb_we),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_data),
        .ex_wreg_i      (ex_wreg),
        .ex_wd_i        (ex_wd),
        .ex_wdata_i     (ex_wdata),
        .mem_wreg_i     (mem_wreg),
        .mem_wd_i       (mem_wd),
        .mem_wdata_i    (mem_wdata),
        .aluop_o        (aluop),
        .alusel_o       (alusel),
        .reg1_o         (reg1),
        .reg2_o         (reg2),
        .wd_o           (wd),
        .wreg_o         (wreg),
        .inst_invalid_o (inst_invalid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h exp %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic drive_idle();
        inst      = '0;
        wb_we     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        ex_wreg   = 1'b0;
        ex_wd     = '0;
        ex_wdata  = '0;
        mem_wreg  = 1'b0;
        mem_wd    = '0;
        mem_wdata = '0;
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [31:0] fld [NUM_COLS];
        fd = $fopen("id_stim.mem", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file id_stim.mem");
        end
        num_vecs = 0;
        line_no  = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;  // comment or blank
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                        fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                        fld[13], fld[14], fld[15], fld[16]);
            if (n != NUM_COLS) begin
                abort_run($sformatf("stimulus line %0d does not hold %0d hex fields",
                                    line_no, NUM_COLS));
            end
            if (num_vecs == MAX_VECS) begin
                abort_run("the stimulus file holds more vectors than the table can take");
            end
            for (int c = 0; c < NUM_COLS; c++) begin
                vec_tab[num_vecs][c] = fld[c];
            end
            num_vecs++;
        end
        $fclose(fd);
        if (num_vecs == 0) begin
            abort_run("the stimulus file holds no vectors");
        end
    endtask

    task automatic apply_vector(input int idx);
        inst      = vec_tab[idx][0];
        wb_we     = vec_tab[idx][1][0];
        wb_addr   = vec_tab[idx][2][REG_ADDR_W-1:0];
        wb_data   = vec_tab[idx][3];
        ex_wreg   = vec_tab[idx][4][0];
        ex_wd     = vec_tab[idx][5][REG_ADDR_W-1:0];
        ex_wdata  = vec_tab[idx][6];
        mem_wreg  = vec_tab[idx][7][0];
        mem_wd    = vec_tab[idx][8][REG_ADDR_W-1:0];
        mem_wdata = vec_tab[idx][9];
    endtask

    task automatic check_outputs(input int idx);
        check("aluop_o", 32'(aluop), vec_tab[idx][10]);
        check("alusel_o", 32'(alusel), vec_tab[idx][11]);
        check("reg1_o", reg1, vec_tab[idx][12]);
        check("reg2_o", reg2, vec_tab[idx][13]);
        check("wd_o", 32'(wd), vec_tab[idx][14]);
        check("wreg_o", 32'(wreg), vec_tab[idx][15]);
        check("inst_invalid_o", 32'(inst_invalid), vec_tab[idx][16]);
    endtask

    initial begin
        clk         = 1'b0;
        reset_i     = 1'b1;
        stim_loaded = 1'b0;
        drive_idle();
        load_stim();
        stim_loaded = 1'b1;
        repeat (RESET_CYC) @(posedge clk);
        #1;
        reset_i = 1'b0;
        // ID/EX register still holds its reset contents here
        check("aluop_o", 32'(aluop), 32'(ALU_NOP));
        check("alusel_o", 32'(alusel), 32'(SEL_NOP));
        check("reg1_o", reg1, 32'h0);
        check("reg2_o", reg2, 32'h0);
        check("wd_o", 32'(wd), 32'h0);
        check("wreg_o", 32'(wreg), 32'h0);
        check("inst_invalid_o", 32'(inst_invalid), 32'h0);
        for (int i = 0; i < num_vecs; i++) begin
            apply_vector(i);
            @(posedge clk);
            #1;  // one cycle latency
            check_outputs(i);
        end
        $display("STATUS: PASS");
        $finish;
    end

    // run length follows the vector count
    initial begin
        wait (stim_loaded === 1'b1);
        #((num_vecs + 10) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", num_vecs + 10);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== id_stim.mem ====
// inst wb_we wb_addr wb_data ex_wreg ex_wd ex_wdata mem_wreg mem_wd mem_wdata, then expected:
// aluop alusel reg1 reg2 wd wreg invalid (all hex, one line per cycle)
34228001 1 01 00001234 0 00 00000000 0 00 00000000 25 1 00001234 00008001 02 1 0
3043ff00 1 02 fffffff0 0 00 00000000 0 00 00000000 24 1 fffffff0 0000ff00 03 1 0
3824a5a5 1 03 80000000 0 00 00000000 0 00 00000000 26 1 00001234 0000a5a5 04 1 0
3c05beef 1 04 00000005 0 00 00000000 0 00 00000000 5c 1 00000000 beef0000 05 1 0
2026fff0 0 00 00000000 0 00 00000000 0 00 00000000 20 4 00001234 fffffff0 06 1 0
24477fff 0 00 00000000 0 00 00000000 0 00 00000000 21 4 fffffff0 00007fff 07 1 0
28688000 0 00 00000000 0 00 00000000 0 00 00000000 2a 4 80000000 ffff8000 08 1 0
2c890001 0 00 00000000 0 00 00000000 0 00 00000000 2b 4 00000005 00000001 09 1 0
00225020 0 00 00000000 0 00 00000000 0 00 00000000 20 4 00001234 fffffff0 0a 1 0
00645827 0 00 00000000 0 00 00000000 0 00 00000000 27 1 80000000 00000005 0b 1 0
0041602b 0 00 00000000 0 00 00000000 0 00 00000000 2b 4 fffffff0 00001234 0c 1 0
00036903 0 00 00000000 0 00 00000000 0 00 00000000 03 2 00000004 80000000 0d 1 0
000177c0 0 00 00000000 0 00 00000000 0 00 00000000 7c 2 0000001f 00001234 0e 1 0
00817806 0 00 00000000 0 00 00000000 0 00 00000000 02 2 00000005 00001234 0f 1 0
00228025 0 00 00000000 1 01 aaaa0001 1 01 bbbb0001 25 1 aaaa0001 fffffff0 10 1 0
00228025 0 00 00000000 1 02 cccc0002 1 01 bbbb0001 25 1 bbbb0001 cccc0002 10 1 0
00a48823 1 05 5a5a5a5a 0 00 00000000 0 00 00000000 23 4 5a5a5a5a 00000005 11 1 0
00059022 1 00 ffffffff 0 00 00000000 0 00 00000000 22 4 00000000 5a5a5a5a 12 1 0
0024980b 0 00 00000000 0 00 00000000 0 00 00000000 0b 3 00001234 00000005 13 1 0
0024980a 0 00 00000000 0 00 00000000 1 04 00000000 0a 3 00001234 00000000 13 1 0
0024980a 0 00 00000000 0 00 00000000 0 00 00000000 0a 3 00001234 00000005 13 0 0
0046a00b 0 00 00000000 1 06 00000001 0 00 00000000 0b 3 fffffff0 00000001 14 1 0
0046a00b 0 00 00000000 0 00 00000000 0 00 00000000 0b 3 fffffff0 00000000 14 0 0
00220018 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 00 0 1
70221802 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 00 0 1
fc221234 0 00 00000000 0 00 00000000 0 00 00000000 00 0 00000000 00000000 00 0 1

// ==== tb.f ====
mips_id_pkg.sv
reg_file.sv
inst_decoder.sv
operand_select.sv
id_stage.sv
tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: mips_id_stage

sources:
  - mips_id_pkg.sv
  - reg_file.sv
  - inst_decoder.sv
  - operand_select.sv
  - id_stage.sv
  - target: test
    files:
      - tb_id_stage.sv
